/* dv/ldq_assert.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_assert (
  input logic                     i_clk,
  input logic                     i_reset_n,
  input logic                     i_psel,
  input logic                     i_penable,
  input logic                     o_pready,
  input logic                     o_pslverr,
  input logic                     o_ld_valid,
  input logic [`LDQ_IDX_W-1:0]    o_ld_idx,
  input logic [`LDQ_CMT_ID_W-1:0] o_ld_cmt_id,
  input logic                     i_ld_ready
);

  // load held under back-pressure
  a_ld_stable: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_ld_valid && !i_ld_ready) |=> (o_ld_valid && $stable(o_ld_idx) && $stable(o_ld_cmt_id)))
    else $error("load port changed while stalled");

  a_pready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_psel && i_penable) |-> o_pready)
    else $error("PREADY low in access phase");

  a_pslverr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_psel && i_penable) |-> !o_pslverr)
    else $error("PSLVERR outside access phase");

endmodule

bind ldq_top ldq_assert u_assert (
  .i_clk (i_clk), .i_reset_n (i_reset_n),
  .i_psel (i_psel), .i_penable (i_penable),
  .o_pready (o_pready), .o_pslverr (o_pslverr),
  .o_ld_valid (o_ld_valid), .o_ld_idx (o_ld_idx), .o_ld_cmt_id (o_ld_cmt_id),
  .i_ld_ready (i_ld_ready)
);

/* dv/ldq_tb.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_tb;

  localparam int N_TRANS   = 600;
  localparam int MAX_CYCLE = 10 * N_TRANS;

  // model entry states
  localparam int S_IDLE   = 0;
  localparam int S_WAIT   = 1;
  localparam int S_ISSUED = 2;
  localparam int S_DONE   = 3;
  localparam int S_DEAD   = 4;

  logic                     clk, reset_n;
  logic                     psel, penable, pwrite, pready, pslverr;
  logic [`LDQ_APB_AW-1:0]   paddr;
  logic [`LDQ_APB_DW-1:0]   pwdata, prdata;
  logic                     phy_valid, ld_valid, ld_ready, resp_valid, resp_replay;
  logic [`LDQ_RNID_W-1:0]   phy_rnid;
  logic [`LDQ_IDX_W-1:0]    ld_idx, resp_idx;
  logic [`LDQ_CMT_ID_W-1:0] ld_cmt_id;

  // reference model
  int                       m_state [`LDQ_DEPTH];
  logic [`LDQ_CMT_ID_W-1:0] m_cmt   [`LDQ_DEPTH];
  logic [`LDQ_RNID_W-1:0]   m_rnid  [`LDQ_DEPTH];
  logic                     m_rdy   [`LDQ_DEPTH];
  logic                     m_disp_v, m_disp_rs1v, m_disp_pre, m_commit_v, m_flush, m_ld_v;
  logic [`LDQ_CMT_ID_W-1:0] m_disp_cmt, m_commit_id, m_ld_cmt, next_id;
  logic [`LDQ_RNID_W-1:0]   m_disp_rnid;
  logic [`LDQ_IDX_W-1:0]    m_ld_idx;

  logic [15:0] lfsr;
  int          cycles = 0;
  int          n_trans, n_accept, n_replay, n_release;

  ldq_top u_dut (
    .i_clk (clk), .i_reset_n (reset_n),
    .i_psel (psel), .i_penable (penable), .i_pwrite (pwrite),
    .i_paddr (paddr), .i_pwdata (pwdata),
    .o_prdata (prdata), .o_pready (pready), .o_pslverr (pslverr),
    .i_phy_wr_valid (phy_valid), .i_phy_wr_rnid (phy_rnid),
    .o_ld_valid (ld_valid), .o_ld_idx (ld_idx), .o_ld_cmt_id (ld_cmt_id),
    .i_ld_ready (ld_ready),
    .i_resp_valid (resp_valid), .i_resp_idx (resp_idx), .i_resp_replay (resp_replay)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int occupancy();
    int n;
    n = 0;
    for (int i = 0; i < `LDQ_DEPTH; i++) begin
      if (m_state[i] != S_IDLE) n++;   // DEAD still counts
    end
    return n;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  // advance the model over one rising edge using the inputs seen at that edge
  task automatic model_step();
    int                     count;
    int                     pick;
    int                     alloc;
    logic                   wr_disp;
    logic                   wr_ctrl;
    logic                   wake;
    logic                   loaded;
    logic [`LDQ_RNID_W-1:0] tag;
    count = occupancy();
    pick  = -1;
    alloc = -1;
    for (int i = `LDQ_DEPTH - 1; i >= 0; i--) begin
      if (m_state[i] == S_WAIT && m_rdy[i] && !m_flush) pick = i;
      if (m_state[i] == S_IDLE) alloc = i;
    end
    if (m_ld_v && ld_ready) n_accept++;
    if (m_ld_v && !ld_ready) pick = -1;   // slot held
    if (pick >= 0) begin
      m_ld_v   = 1'b1;
      m_ld_idx = `LDQ_IDX_W'(pick);
      m_ld_cmt = m_cmt[pick];
    end else if (ld_ready) begin
      m_ld_v = 1'b0;
    end
    for (int i = 0; i < `LDQ_DEPTH; i++) begin
      tag    = (m_disp_v && alloc == i) ? m_disp_rnid : m_rnid[i];
      wake   = phy_valid && (tag == phy_rnid);
      loaded = m_disp_v && alloc == i && !m_flush;
      if (m_flush) begin
        if (m_state[i] != S_IDLE) m_state[i] = S_DEAD;
      end else if (loaded) begin
        m_state[i] = S_WAIT;
      end else if (m_state[i] == S_WAIT && pick == i) begin
        m_state[i] = S_ISSUED;
      end else if (m_state[i] == S_ISSUED && resp_valid && int'(resp_idx) == i) begin
        m_state[i] = resp_replay ? S_WAIT : S_DONE;
        if (resp_replay) n_replay++;
      end else if ((m_state[i] == S_DONE || m_state[i] == S_DEAD) && m_commit_v &&
                   m_commit_id == m_cmt[i]) begin
        m_state[i] = S_IDLE;
        n_release++;
      end
      m_rdy[i] = loaded ? (!m_disp_rs1v || m_disp_pre || wake) : (m_rdy[i] || wake);
      if (loaded) begin
        m_cmt[i]  = m_disp_cmt;
        m_rnid[i] = m_disp_rnid;
      end
    end
    // APB front pulses for the next edge
    wr_disp  = psel && penable && pwrite && (paddr == `LDQ_ADDR_DISP);
    wr_ctrl  = psel && penable && pwrite && (paddr == `LDQ_ADDR_CTRL);
    m_disp_v = wr_disp && (count < `LDQ_DEPTH);
    if (wr_disp) begin
      m_disp_cmt  = pwdata[5:0];
      m_disp_rs1v = pwdata[6];
      m_disp_rnid = pwdata[11:7];
      m_disp_pre  = pwdata[12];
    end
    m_commit_v = wr_ctrl && pwdata[6];
    m_flush    = wr_ctrl && pwdata[7];
    if (wr_ctrl) m_commit_id = pwdata[5:0];
  endtask

  task automatic drive_inputs();
    logic [1:0] op;
    logic       flush;
    if (psel && !penable) begin
      penable = 1'b1;
    end else if (psel) begin
      psel    = 1'b0;
      penable = 1'b0;
      n_trans++;
    end else if (next_bits(1) != 0) begin
      op      = 2'(next_bits(2));
      psel    = 1'b1;
      pwrite  = 1'b1;
      if (op[1] == 1'b0) begin   // dispatch on half the ops
        paddr   = `LDQ_ADDR_DISP;
        pwdata  = {19'd0, next_bits(2) == 0, `LDQ_RNID_W'(next_bits(3)),
                   next_bits(1) != 0, next_id};
        next_id = next_id + `LDQ_CMT_ID_W'(1);
      end else if (op[0] == 1'b0) begin
        flush  = next_bits(4) == 0;
        paddr  = `LDQ_ADDR_CTRL;
        pwdata = {24'd0, flush, !flush, m_cmt[`LDQ_IDX_W'(next_bits(2))]};
      end else begin
        paddr  = `LDQ_ADDR_STAT;
        pwrite = 1'b0;
        pwdata = '0;
      end
    end
    phy_valid   = next_bits(2) == 0;
    phy_rnid    = `LDQ_RNID_W'(next_bits(3));
    ld_ready    = next_bits(2) != 0;
    resp_valid  = next_bits(2) == 0;
    resp_idx    = `LDQ_IDX_W'(next_bits(2));
    resp_replay = next_bits(2) == 0;
  endtask

  task automatic check_outputs();
    logic        access;
    logic [31:0] stat;
    access = psel && penable;
    stat   = 32'(occupancy());
    if (occupancy() == `LDQ_DEPTH) stat[`LDQ_STAT_FULL_BIT] = 1'b1;
    check_eq("o_ld_valid", 32'(ld_valid), 32'(m_ld_v));
    if (m_ld_v) begin
      check_eq("o_ld_idx", 32'(ld_idx), 32'(m_ld_idx));
      check_eq("o_ld_cmt_id", 32'(ld_cmt_id), 32'(m_ld_cmt));
    end
    if (access) check_eq("o_pready", 32'(pready), 32'd1);
    check_eq("o_pslverr", 32'(pslverr), 32'(access && pwrite && paddr == `LDQ_ADDR_DISP &&
                                            occupancy() == `LDQ_DEPTH));
    if (access && !pwrite) check_eq("o_prdata", prdata, stat);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLE) begin
      $display("Timeout: run passed %0d cycles before all transactions ended", MAX_CYCLE);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    lfsr = 16'd52;
    {psel, penable, pwrite, paddr, pwdata} = '0;
    {phy_valid, phy_rnid, ld_ready, resp_valid, resp_idx, resp_replay} = '0;
    {m_disp_v, m_disp_rs1v, m_disp_pre, m_commit_v, m_flush, m_ld_v} = '0;
    {m_disp_cmt, m_commit_id, m_ld_cmt, next_id, m_disp_rnid, m_ld_idx} = '0;
    for (int i = 0; i < `LDQ_DEPTH; i++) begin
      m_state[i] = S_IDLE;
      m_cmt[i]   = '0;
      m_rnid[i]  = '0;
      m_rdy[i]   = 1'b0;
    end
    n_trans   = 0;
    n_accept  = 0;
    n_replay  = 0;
    n_release = 0;
    reset_n   = 1'b0;
    repeat (4) @(posedge clk);
    #2 reset_n = 1'b1;
    while (n_trans < N_TRANS) begin
      @(posedge clk);
      model_step();
      #2 drive_inputs();
      #1 check_outputs();
    end
    if (n_accept == 0 || n_replay == 0 || n_release == 0) begin
      $display("Fail: run ended without accepted loads, replays or commit releases");
      $display("Errors found");
      $fatal(1, "stimulus did not reach the queue behaviors");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

/* hdl/ldq_apb_front.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_apb_front (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [`LDQ_APB_AW-1:0]   i_paddr,
  input  logic [`LDQ_APB_DW-1:0]   i_pwdata,
  output logic [`LDQ_APB_DW-1:0]   o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,

  input  logic                     i_full,
  input  logic [`LDQ_CNT_W-1:0]    i_count,

  output logic                     o_disp_valid,
  output logic [`LDQ_CMT_ID_W-1:0] o_disp_cmt_id,
  output logic                     o_disp_rs1_valid,
  output logic [`LDQ_RNID_W-1:0]   o_disp_rs1_rnid,
  output logic                     o_disp_pre_ready,

  output logic                     o_commit_valid,
  output logic [`LDQ_CMT_ID_W-1:0] o_commit_cmt_id,
  output logic                     o_flush
);

  logic                w_access;
  logic                w_wr_disp;
  logic                w_wr_ctrl;
  ldq_pkg::ldq_wdata_u w_wdata;

  assign w_access  = i_psel & i_penable;
  assign w_wdata   = i_pwdata;
  assign w_wr_disp = w_access & i_pwrite & (i_paddr == `LDQ_ADDR_DISP);
  assign w_wr_ctrl = w_access & i_pwrite & (i_paddr == `LDQ_ADDR_CTRL);

  assign o_pready  = 1'b1;               // no wait states
  assign o_pslverr = w_wr_disp & i_full; // dispatch into a full queue

  // status read mux
  always_comb begin
    o_prdata = '0;
    if (!i_pwrite && (i_paddr == `LDQ_ADDR_STAT)) begin
      o_prdata[`LDQ_CNT_W-1:0]     = i_count;
      o_prdata[`LDQ_STAT_FULL_BIT] = i_full;
    end
  end

  // one-cycle pulses, the cycle after the access phase
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_disp_valid   <= 1'b0;
      o_commit_valid <= 1'b0;
      o_flush        <= 1'b0;
    end else begin
      o_disp_valid   <= w_wr_disp & ~i_full;  // dropped when full
      o_commit_valid <= w_wr_ctrl & w_wdata.ctrl.commit;
      o_flush        <= w_wr_ctrl & w_wdata.ctrl.flush;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_wr_disp) begin
      o_disp_cmt_id    <= w_wdata.disp.cmt_id;
      o_disp_rs1_valid <= w_wdata.disp.rs1_valid;
      o_disp_rs1_rnid  <= w_wdata.disp.rs1_rnid;
      o_disp_pre_ready <= w_wdata.disp.pre_ready;
    end
    if (w_wr_ctrl) begin
      o_commit_cmt_id <= w_wdata.ctrl.cmt_id;
    end
  end

endmodule

/* hdl/ldq_array.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_array (
  input  logic                                     i_clk,
  input  logic                                     i_reset_n,

  input  logic                                     i_disp_valid,
  input  logic [`LDQ_CMT_ID_W-1:0]                 i_disp_cmt_id,
  input  logic                                     i_disp_rs1_valid,
  input  logic [`LDQ_RNID_W-1:0]                   i_disp_rs1_rnid,
  input  logic                                     i_disp_pre_ready,

  input  logic                                     i_phy_wr_valid,
  input  logic [`LDQ_RNID_W-1:0]                   i_phy_wr_rnid,

  input  logic                                     i_pick_valid,
  input  logic [`LDQ_IDX_W-1:0]                    i_pick_idx,

  input  logic                                     i_resp_valid,
  input  logic [`LDQ_IDX_W-1:0]                    i_resp_idx,
  input  logic                                     i_resp_replay,

  input  logic                                     i_commit_valid,
  input  logic [`LDQ_CMT_ID_W-1:0]                 i_commit_cmt_id,
  input  logic                                     i_flush,

  output logic [`LDQ_DEPTH-1:0]                    o_ready_mask,
  output logic [`LDQ_DEPTH-1:0][`LDQ_CMT_ID_W-1:0] o_cmt_ids,
  output logic                                     o_full,
  output logic [`LDQ_CNT_W-1:0]                    o_count
);

  ldq_pkg::ldq_state_e     w_state [`LDQ_DEPTH];
  logic [`LDQ_DEPTH-1:0]   w_alloc_oh;

  // lowest IDLE entry gets the dispatch, count includes DEAD entries
  always_comb begin
    logic found;
    found      = 1'b0;
    w_alloc_oh = '0;
    o_count    = '0;
    for (int i = 0; i < `LDQ_DEPTH; i++) begin
      if (!found && (w_state[i] == ldq_pkg::IDLE)) begin
        w_alloc_oh[i] = 1'b1;
        found         = 1'b1;
      end
      if (w_state[i] != ldq_pkg::IDLE) o_count = o_count + `LDQ_CNT_W'(1);
    end
    o_full = ~found;
  end

  for (genvar g = 0; g < `LDQ_DEPTH; g++) begin : g_entry
    ldq_entry u_entry (
      .i_clk            (i_clk),
      .i_reset_n        (i_reset_n),
      .i_alloc          (i_disp_valid & w_alloc_oh[g]),
      .i_disp_cmt_id    (i_disp_cmt_id),
      .i_disp_rs1_valid (i_disp_rs1_valid),
      .i_disp_rs1_rnid  (i_disp_rs1_rnid),
      .i_disp_pre_ready (i_disp_pre_ready),
      .i_phy_wr_valid   (i_phy_wr_valid),
      .i_phy_wr_rnid    (i_phy_wr_rnid),
      .i_pick           (i_pick_valid & (i_pick_idx == `LDQ_IDX_W'(g))),
      .i_resp_hit       (i_resp_valid & (i_resp_idx == `LDQ_IDX_W'(g))),
      .i_resp_replay    (i_resp_replay),
      .i_commit_valid   (i_commit_valid),
      .i_commit_cmt_id  (i_commit_cmt_id),
      .i_flush          (i_flush),
      .o_state          (w_state[g]),
      .o_ready          (o_ready_mask[g]),
      .o_cmt_id         (o_cmt_ids[g])
    );
  end

endmodule

/* hdl/ldq_entry.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_entry (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_alloc,
  input  logic [`LDQ_CMT_ID_W-1:0] i_disp_cmt_id,
  input  logic                     i_disp_rs1_valid,
  input  logic [`LDQ_RNID_W-1:0]   i_disp_rs1_rnid,
  input  logic                     i_disp_pre_ready,

  input  logic                     i_phy_wr_valid,
  input  logic [`LDQ_RNID_W-1:0]   i_phy_wr_rnid,

  input  logic                     i_pick,
  input  logic                     i_resp_hit,
  input  logic                     i_resp_replay,

  input  logic                     i_commit_valid,
  input  logic [`LDQ_CMT_ID_W-1:0] i_commit_cmt_id,
  input  logic                     i_flush,

  output ldq_pkg::ldq_state_e      o_state,
  output logic                     o_ready,
  output logic [`LDQ_CMT_ID_W-1:0] o_cmt_id
);

  ldq_pkg::ldq_state_e      r_state;
  ldq_pkg::ldq_state_e      w_state_next;
  logic [`LDQ_CMT_ID_W-1:0] r_cmt_id;
  logic [`LDQ_RNID_W-1:0]   r_rs1_rnid;
  logic                     r_rs1_ready;
  logic [`LDQ_RNID_W-1:0]   w_rs1_rnid;
  logic                     w_wake;
  logic                     w_load;
  logic                     w_release;

  // compare against the incoming tag on the dispatch cycle
  assign w_rs1_rnid = i_alloc ? i_disp_rs1_rnid : r_rs1_rnid;
  assign w_wake     = i_phy_wr_valid & (w_rs1_rnid == i_phy_wr_rnid);

  assign w_load    = (r_state == ldq_pkg::IDLE) & i_alloc & ~i_flush;
  assign w_release = i_commit_valid & (i_commit_cmt_id == r_cmt_id);

  always_comb begin
    w_state_next = r_state;
    if (i_flush) begin
      if (r_state != ldq_pkg::IDLE) w_state_next = ldq_pkg::DEAD;
    end else begin
      case (r_state)
        ldq_pkg::IDLE:       if (i_alloc) w_state_next = ldq_pkg::ISSUE_WAIT;
        ldq_pkg::ISSUE_WAIT: if (i_pick) w_state_next = ldq_pkg::ISSUED;
        ldq_pkg::ISSUED: begin
          if (i_resp_hit) begin
            w_state_next = i_resp_replay ? ldq_pkg::ISSUE_WAIT : ldq_pkg::DONE;
          end
        end
        ldq_pkg::DONE,
        ldq_pkg::DEAD:       if (w_release) w_state_next = ldq_pkg::IDLE;
        default:             w_state_next = ldq_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state     <= ldq_pkg::IDLE;
      r_rs1_ready <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (w_load) begin
        r_rs1_ready <= ~i_disp_rs1_valid | i_disp_pre_ready | w_wake;
      end else begin
        r_rs1_ready <= r_rs1_ready | w_wake;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_load) begin
      r_cmt_id   <= i_disp_cmt_id;
      r_rs1_rnid <= i_disp_rs1_rnid;
    end
  end

  assign o_state  = r_state;
  assign o_ready  = (r_state == ldq_pkg::ISSUE_WAIT) & r_rs1_ready & ~i_flush; // no pick on flush
  assign o_cmt_id = r_cmt_id;

endmodule

/* hdl/ldq_issue_unit.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_issue_unit (
  input  logic                                     i_clk,
  input  logic                                     i_reset_n,

  input  logic [`LDQ_DEPTH-1:0]                    i_ready_mask,
  input  logic [`LDQ_DEPTH-1:0][`LDQ_CMT_ID_W-1:0] i_cmt_ids,

  output logic                                     o_pick_valid,
  output logic [`LDQ_IDX_W-1:0]                    o_pick_idx,

  output logic                                     o_ld_valid,
  output logic [`LDQ_IDX_W-1:0]                    o_ld_idx,
  output logic [`LDQ_CMT_ID_W-1:0]                 o_ld_cmt_id,
  input  logic                                     i_ld_ready
);

  logic                 w_slot_free;
  logic [`LDQ_IDX_W-1:0] w_first_idx;

  // lowest index wins
  always_comb begin
    w_first_idx = '0;
    for (int i = `LDQ_DEPTH - 1; i >= 0; i--) begin
      if (i_ready_mask[i]) w_first_idx = `LDQ_IDX_W'(i);
    end
  end

  assign w_slot_free  = ~o_ld_valid | i_ld_ready;   // empty or draining
  assign o_pick_valid = w_slot_free & (|i_ready_mask);
  assign o_pick_idx   = w_first_idx;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ld_valid <= 1'b0;
    end else if (o_pick_valid) begin
      o_ld_valid <= 1'b1;
    end else if (i_ld_ready) begin
      o_ld_valid <= 1'b0;
    end
  end

  // held under back-pressure
  always_ff @(posedge i_clk) begin
    if (o_pick_valid) begin
      o_ld_idx    <= w_first_idx;
      o_ld_cmt_id <= i_cmt_ids[w_first_idx];
    end
  end

endmodule

/* hdl/ldq_pkg.sv */
`include "ldq_macros.svh"

package ldq_pkg;

  // life of one load
  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    ISSUE_WAIT = 3'd1,
    ISSUED     = 3'd2,
    DONE       = 3'd3,
    DEAD       = 3'd4
  } ldq_state_e;

  // DISP write word, cmt_id in the low bits
  typedef struct packed {
    logic [`LDQ_APB_DW-`LDQ_CMT_ID_W-`LDQ_RNID_W-3:0] pad;
    logic                                           pre_ready;
    logic [`LDQ_RNID_W-1:0]                         rs1_rnid;
    logic                                           rs1_valid;
    logic [`LDQ_CMT_ID_W-1:0]                       cmt_id;
  } ldq_disp_t;

  // CTRL write word
  typedef struct packed {
    logic [`LDQ_APB_DW-`LDQ_CMT_ID_W-3:0] pad;
    logic                               flush;
    logic                               commit;
    logic [`LDQ_CMT_ID_W-1:0]           cmt_id;
  } ldq_ctrl_t;

  // one APB word, the address picks the view
  typedef union packed {
    ldq_disp_t disp;
    ldq_ctrl_t ctrl;
  } ldq_wdata_u;

endpackage

/* hdl/ldq_top.sv */
`timescale 1ns/1ps
`include "ldq_macros.svh"

module ldq_top (
  input  logic                     i_clk,
  input  logic                     i_reset_n,

  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  logic [`LDQ_APB_AW-1:0]   i_paddr,
  input  logic [`LDQ_APB_DW-1:0]   i_pwdata,
  output logic [`LDQ_APB_DW-1:0]   o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,

  input  logic                     i_phy_wr_valid,
  input  logic [`LDQ_RNID_W-1:0]   i_phy_wr_rnid,

  output logic                     o_ld_valid,
  output logic [`LDQ_IDX_W-1:0]    o_ld_idx,
  output logic [`LDQ_CMT_ID_W-1:0] o_ld_cmt_id,
  input  logic                     i_ld_ready,

  input  logic                     i_resp_valid,
  input  logic [`LDQ_IDX_W-1:0]    i_resp_idx,
  input  logic                     i_resp_replay
);

  logic                                     w_full;
  logic [`LDQ_CNT_W-1:0]                    w_count;
  logic                                     w_disp_valid;
  logic [`LDQ_CMT_ID_W-1:0]                 w_disp_cmt_id;
  logic                                     w_disp_rs1_valid;
  logic [`LDQ_RNID_W-1:0]                   w_disp_rs1_rnid;
  logic                                     w_disp_pre_ready;
  logic                                     w_commit_valid;
  logic [`LDQ_CMT_ID_W-1:0]                 w_commit_cmt_id;
  logic                                     w_flush;
  logic [`LDQ_DEPTH-1:0]                    w_ready_mask;
  logic [`LDQ_DEPTH-1:0][`LDQ_CMT_ID_W-1:0] w_cmt_ids;
  logic                                     w_pick_valid;
  logic [`LDQ_IDX_W-1:0]                    w_pick_idx;

  ldq_apb_front u_front (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata),
    .o_prdata (o_prdata), .o_pready (o_pready), .o_pslverr (o_pslverr),
    .i_full (w_full), .i_count (w_count),
    .o_disp_valid (w_disp_valid), .o_disp_cmt_id (w_disp_cmt_id),
    .o_disp_rs1_valid (w_disp_rs1_valid), .o_disp_rs1_rnid (w_disp_rs1_rnid),
    .o_disp_pre_ready (w_disp_pre_ready),
    .o_commit_valid (w_commit_valid), .o_commit_cmt_id (w_commit_cmt_id),
    .o_flush (w_flush)
  );

  ldq_array u_array (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_disp_valid (w_disp_valid), .i_disp_cmt_id (w_disp_cmt_id),
    .i_disp_rs1_valid (w_disp_rs1_valid), .i_disp_rs1_rnid (w_disp_rs1_rnid),
    .i_disp_pre_ready (w_disp_pre_ready),
    .i_phy_wr_valid (i_phy_wr_valid), .i_phy_wr_rnid (i_phy_wr_rnid),
    .i_pick_valid (w_pick_valid), .i_pick_idx (w_pick_idx),
    .i_resp_valid (i_resp_valid), .i_resp_idx (i_resp_idx),
    .i_resp_replay (i_resp_replay),
    .i_commit_valid (w_commit_valid), .i_commit_cmt_id (w_commit_cmt_id),
    .i_flush (w_flush),
    .o_ready_mask (w_ready_mask), .o_cmt_ids (w_cmt_ids),
    .o_full (w_full), .o_count (w_count)
  );

  ldq_issue_unit u_issue (
    .i_clk (i_clk), .i_reset_n (i_reset_n),
    .i_ready_mask (w_ready_mask), .i_cmt_ids (w_cmt_ids),
    .o_pick_valid (w_pick_valid), .o_pick_idx (w_pick_idx),
    .o_ld_valid (o_ld_valid), .o_ld_idx (o_ld_idx), .o_ld_cmt_id (o_ld_cmt_id),
    .i_ld_ready (i_ld_ready)
  );

endmodule

/* include/ldq_macros.svh */
`ifndef LDQ_MACROS_SVH
`define LDQ_MACROS_SVH

// queue geometry
`define LDQ_DEPTH        4
`define LDQ_IDX_W        2
`define LDQ_CNT_W        3   // holds 0..LDQ_DEPTH

// tags carried by each load
`define LDQ_CMT_ID_W     6
`define LDQ_RNID_W       5

// APB slave
`define LDQ_APB_AW       4
`define LDQ_APB_DW       32

// register map
`define LDQ_ADDR_DISP    4'h0
`define LDQ_ADDR_CTRL    4'h4
`define LDQ_ADDR_STAT    4'h8

// status word layout, count sits in the low bits
`define LDQ_STAT_FULL_BIT 8

`endif

/* run_sim.sh */
#!/bin/sh
# build and run the load queue testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ldq_tb -o ldq_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ldq_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "No errors" sim.log; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

/* src.f */
+incdir+include
hdl/ldq_pkg.sv
hdl/ldq_apb_front.sv
hdl/ldq_entry.sv
hdl/ldq_array.sv
hdl/ldq_issue_unit.sv
hdl/ldq_top.sv
dv/ldq_assert.sv
dv/ldq_tb.sv
